// File: hw/accumTree.sv
`timescale 1ns/1ps

module accumTree import fp16Pkg::*; (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic start,
	input  logic [WordWidth-1:0] accumIn0,
	input  logic [WordWidth-1:0] accumIn1,
	input  logic [WordWidth-1:0] accumIn2,
	input  logic [WordWidth-1:0] accumIn3,
	output logic done,
	output logic [WordWidth-1:0] sum,
	output logic idle
);
	logic pairValid;                    // Both level-one adders run in step
	logic [WordWidth-1:0] lowPairSum;   // in1 + in0
	logic [WordWidth-1:0] highPairSum;  // in3 + in2
	logic finalValid;
	logic [WordWidth-1:0] finalSum;
	logic [WordWidth-1:0] sumHold;      // Last delivered sum
	logic [2:0] inFlight;               // At most TreeLatency items

	// Level one, operands go straight in on start
	fpAdder firstPairAdd (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.inValid(start),
		.opA(accumIn1),
		.opB(accumIn0),
		.outValid(pairValid),
		.result(lowPairSum)
	);

	fpAdder secondPairAdd (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.inValid(start),
		.opA(accumIn3),
		.opB(accumIn2),
		.outValid(),            // Same timing as pairValid
		.result(highPairSum)
	);

	// Level two
	fpAdder finalAdd (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.inValid(pairValid),
		.opA(highPairSum),
		.opB(lowPairSum),
		.outValid(finalValid),
		.result(finalSum)
	);

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			sumHold <= '0;
		end else if (finalValid) begin
			sumHold <= finalSum;
		end
	end

	// Fresh result in the done cycle, held value otherwise
	assign done = finalValid;
	assign sum = finalValid ? finalSum : sumHold;

	// Items between start and done
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			inFlight <= 3'd0;
		end else begin
			case ({start, finalValid})
				2'b10: inFlight <= inFlight + 3'd1;
				2'b01: inFlight <= inFlight - 3'd1;
				default: inFlight <= inFlight;   // None, or one in and one out
			endcase
		end
	end

	assign idle = (inFlight == 3'd0) && !start;

endmodule

// File: hw/fp16Pkg.sv
package fp16Pkg;

	// IEEE 754 binary16 layout
	localparam int WordWidth = 16;
	localparam int ExpWidth = 5;
	localparam int ManWidth = 10;
	localparam int ExpBias = 15;
	localparam int ExpMax = 31;     // Inf / NaN exponent

	// Guard, round and sticky below the stored mantissa
	localparam int GuardBits = 3;

	// Pipeline depths
	localparam int AdderLatency = 3;            // align, add/normalize, round
	localparam int TreeLatency = 2 * AdderLatency;

	// Quiet NaN returned for every invalid result
	localparam logic [WordWidth-1:0] CanonNaN = 16'h7E00;

	// One fp16 word, seen as raw bits or as its fields
	typedef union packed {
		logic [WordWidth-1:0] raw;
		struct packed {
			logic sign;
			logic [ExpWidth-1:0] exponent;
			logic [ManWidth-1:0] mantissa;
		} fields;
	} halfWord_u;

endpackage

// File: hw/fpAddNorm.sv
`timescale 1ns/1ps

module fpAddNorm import fp16Pkg::*; (
	input  logic bigSign,
	input  logic smallSign,
	input  logic [ExpWidth-1:0] bigExp,
	input  logic [ManWidth:0] bigMan,
	input  logic [ManWidth+GuardBits:0] smallManAligned,
	input  logic specialValid,
	input  logic [WordWidth-1:0] specialWord,
	output logic resSign,
	output logic signed [ExpWidth+1:0] normExp,     // May leave the 1..30 range
	output logic [ManWidth+GuardBits:0] normMan,    // Hidden one at MSB, GRS at LSBs
	output logic isZero,
	output logic specialValidOut,
	output logic [WordWidth-1:0] specialWordOut
);
	logic effSub;
	logic [ManWidth+GuardBits:0] bigExt;
	logic [ManWidth+GuardBits+1:0] rawSum;   // One carry bit on top
	logic [3:0] lzCount;
	logic signed [ExpWidth+1:0] baseExp;

	assign effSub = bigSign ^ smallSign;   // Opposite signs subtract
	assign bigExt = {bigMan, {GuardBits{1'b0}}};

	// Big operand is never smaller, so the difference stays positive
	assign rawSum = effSub ?
		({1'b0, bigExt} - {1'b0, smallManAligned}) :
		({1'b0, bigExt} + {1'b0, smallManAligned});

	assign isZero = (rawSum == '0);
	assign resSign = (effSub && isZero) ? 1'b0 : bigSign;   // Exact cancellation is +0
	assign baseExp = $signed({2'b00, bigExp});

	// Leading zeros below the carry bit; highest set bit wins
	always_comb begin
		lzCount = 4'(ManWidth + GuardBits + 1);
		for (int i = 0; i <= ManWidth + GuardBits; i++) begin
			if (rawSum[i]) begin
				lzCount = 4'(ManWidth + GuardBits - i);
			end
		end
	end

	always_comb begin
		if (rawSum[ManWidth+GuardBits+1]) begin
			// Carry out, one step right with the dropped bit folded into sticky
			normMan = {rawSum[ManWidth+GuardBits+1:2], rawSum[1] | rawSum[0]};
			normExp = baseExp + 7'sd1;
		end else begin
			normMan = rawSum[ManWidth+GuardBits:0] << lzCount;
			normExp = baseExp - $signed({3'b000, lzCount});
		end
	end

	// Specials ride along to the round stage
	assign specialValidOut = specialValid;
	assign specialWordOut = specialWord;

endmodule

// File: hw/fpAdder.sv
`timescale 1ns/1ps

module fpAdder import fp16Pkg::*; (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic inValid,
	input  logic [WordWidth-1:0] opA,
	input  logic [WordWidth-1:0] opB,
	output logic outValid,
	output logic [WordWidth-1:0] result
);
	// Align stage outputs and rank 1
	logic alBigSign;
	logic alSmallSign;
	logic [ExpWidth-1:0] alBigExp;
	logic [ManWidth:0] alBigMan;
	logic [ManWidth+GuardBits:0] alSmallMan;
	logic alSpecialValid;
	logic [WordWidth-1:0] alSpecialWord;
	logic r1Valid;
	logic r1BigSign;
	logic r1SmallSign;
	logic [ExpWidth-1:0] r1BigExp;
	logic [ManWidth:0] r1BigMan;
	logic [ManWidth+GuardBits:0] r1SmallMan;
	logic r1SpecialValid;
	logic [WordWidth-1:0] r1SpecialWord;

	// Add/normalize outputs and rank 2
	logic anResSign;
	logic signed [ExpWidth+1:0] anNormExp;
	logic [ManWidth+GuardBits:0] anNormMan;
	logic anIsZero;
	logic anSpecialValid;
	logic [WordWidth-1:0] anSpecialWord;
	logic r2Valid;
	logic r2ResSign;
	logic signed [ExpWidth+1:0] r2NormExp;
	logic [ManWidth+GuardBits:0] r2NormMan;
	logic r2IsZero;
	logic r2SpecialValid;
	logic [WordWidth-1:0] r2SpecialWord;

	logic [WordWidth-1:0] rdResult;   // Round stage out, rank 3 is result itself

	fpAlign align_i (
		.opA(opA),
		.opB(opB),
		.bigSign(alBigSign),
		.smallSign(alSmallSign),
		.bigExp(alBigExp),
		.bigMan(alBigMan),
		.smallManAligned(alSmallMan),
		.specialValid(alSpecialValid),
		.specialWord(alSpecialWord)
	);

	fpAddNorm addNorm_i (
		.bigSign(r1BigSign),
		.smallSign(r1SmallSign),
		.bigExp(r1BigExp),
		.bigMan(r1BigMan),
		.smallManAligned(r1SmallMan),
		.specialValid(r1SpecialValid),
		.specialWord(r1SpecialWord),
		.resSign(anResSign),
		.normExp(anNormExp),
		.normMan(anNormMan),
		.isZero(anIsZero),
		.specialValidOut(anSpecialValid),
		.specialWordOut(anSpecialWord)
	);

	fpRound round_i (
		.resSign(r2ResSign),
		.normExp(r2NormExp),
		.normMan(r2NormMan),
		.isZero(r2IsZero),
		.specialValid(r2SpecialValid),
		.specialWord(r2SpecialWord),
		.result(rdResult)
	);

	// Valid bits, one per rank
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			r1Valid <= 1'b0;
			r2Valid <= 1'b0;
			outValid <= 1'b0;
		end else begin
			r1Valid <= inValid;
			r2Valid <= r1Valid;
			outValid <= r2Valid;
		end
	end

	// Data ranks load every cycle, a new pair may enter each clock
	always_ff @(posedge ap_clk) begin
		r1BigSign <= alBigSign;
		r1SmallSign <= alSmallSign;
		r1BigExp <= alBigExp;
		r1BigMan <= alBigMan;
		r1SmallMan <= alSmallMan;
		r1SpecialValid <= alSpecialValid;
		r1SpecialWord <= alSpecialWord;
		r2ResSign <= anResSign;
		r2NormExp <= anNormExp;
		r2NormMan <= anNormMan;
		r2IsZero <= anIsZero;
		r2SpecialValid <= anSpecialValid;
		r2SpecialWord <= anSpecialWord;
		result <= rdResult;
	end

endmodule

// File: hw/fpAlign.sv
`timescale 1ns/1ps

module fpAlign import fp16Pkg::*; (
	input  halfWord_u opA,
	input  halfWord_u opB,
	output logic bigSign,
	output logic smallSign,
	output logic [ExpWidth-1:0] bigExp,
	output logic [ManWidth:0] bigMan,                    // Hidden one on top
	output logic [ManWidth+GuardBits:0] smallManAligned, // Shifted, GRS at bottom
	output logic specialValid,
	output logic [WordWidth-1:0] specialWord
);
	logic aZero;
	logic bZero;
	logic aNaN;
	logic bNaN;
	logic aInf;
	logic bInf;
	logic [WordWidth-2:0] aMag;   // Magnitude after subnormal flush
	logic [WordWidth-2:0] bMag;
	logic swap;                   // B is the larger operand
	logic [ExpWidth-1:0] smallExp;
	logic [ManWidth:0] smallMan;
	logic [ExpWidth-1:0] expDiff;
	logic [3:0] shiftAmt;
	logic [2*(ManWidth+GuardBits+1)-1:0] alignWide;

	// Zero exponent covers zero and subnormals
	assign aZero = (opA.fields.exponent == '0);
	assign bZero = (opB.fields.exponent == '0);
	assign aNaN = (opA.fields.exponent == ExpWidth'(ExpMax)) && (opA.fields.mantissa != '0);
	assign bNaN = (opB.fields.exponent == ExpWidth'(ExpMax)) && (opB.fields.mantissa != '0);
	assign aInf = (opA.fields.exponent == ExpWidth'(ExpMax)) && (opA.fields.mantissa == '0);
	assign bInf = (opB.fields.exponent == ExpWidth'(ExpMax)) && (opB.fields.mantissa == '0);

	assign aMag = aZero ? '0 : opA.raw[WordWidth-2:0];
	assign bMag = bZero ? '0 : opB.raw[WordWidth-2:0];

	// Exponent and mantissa sit together, so one compare orders them
	assign swap = (bMag > aMag);

	assign bigSign = swap ? opB.fields.sign : opA.fields.sign;
	assign smallSign = swap ? opA.fields.sign : opB.fields.sign;
	assign bigExp = swap ? bMag[WordWidth-2:ManWidth] : aMag[WordWidth-2:ManWidth];
	assign smallExp = swap ? aMag[WordWidth-2:ManWidth] : bMag[WordWidth-2:ManWidth];
	assign bigMan = swap ? {~bZero, bMag[ManWidth-1:0]} : {~aZero, aMag[ManWidth-1:0]};
	assign smallMan = swap ? {~aZero, aMag[ManWidth-1:0]} : {~bZero, bMag[ManWidth-1:0]};

	assign expDiff = bigExp - smallExp;   // Never negative
	assign shiftAmt = (expDiff > 5'd15) ? 4'd15 : expDiff[3:0]; // Beyond 15 all bits are sticky anyway

	// Upper half keeps the aligned value, lower half catches what falls off
	assign alignWide = {smallMan, {GuardBits{1'b0}}, {(ManWidth+GuardBits+1){1'b0}}} >> shiftAmt;
	assign smallManAligned = {alignWide[2*(ManWidth+GuardBits+1)-1:ManWidth+GuardBits+2],
		|alignWide[ManWidth+GuardBits+1:0]};

	assign specialValid = aNaN | bNaN | aInf | bInf;

	always_comb begin
		if (aNaN || bNaN) begin
			specialWord = CanonNaN;
		end else if (aInf && bInf && (opA.fields.sign != opB.fields.sign)) begin
			specialWord = CanonNaN;   // inf - inf
		end else if (aInf) begin
			specialWord = opA.raw;
		end else begin
			specialWord = opB.raw;
		end
	end

endmodule

// File: hw/fpRound.sv
`timescale 1ns/1ps

module fpRound import fp16Pkg::*; (
	input  logic resSign,
	input  logic signed [ExpWidth+1:0] normExp,
	input  logic [ManWidth+GuardBits:0] normMan,
	input  logic isZero,
	input  logic specialValid,
	input  logic [WordWidth-1:0] specialWord,
	output logic [WordWidth-1:0] result
);
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [ManWidth+1:0] rounded;   // Hidden one plus carry room
	logic signed [ExpWidth+1:0] finalExp;
	logic [ManWidth-1:0] finalMan;
	halfWord_u packedWord;

	assign guardBit = normMan[GuardBits-1];
	assign roundBit = normMan[GuardBits-2];
	assign stickyBit = normMan[0];

	// Nearest even, mantissa LSB breaks the tie
	assign roundUp = guardBit & (roundBit | stickyBit | normMan[GuardBits]);
	assign rounded = {1'b0, normMan[ManWidth+GuardBits:GuardBits]} +
		{{(ManWidth+1){1'b0}}, roundUp};

	// 1.11..1 rounding up lands on 10.00..0
	assign finalExp = normExp + $signed({{(ExpWidth+1){1'b0}}, rounded[ManWidth+1]});
	assign finalMan = rounded[ManWidth+1] ? rounded[ManWidth:1] : rounded[ManWidth-1:0];

	always_comb begin
		packedWord.fields.sign = resSign;
		packedWord.fields.exponent = finalExp[ExpWidth-1:0];
		packedWord.fields.mantissa = finalMan;
		if (specialValid) begin
			packedWord.raw = specialWord;   // NaN or inf from the inputs
		end else if (isZero || finalExp <= 0) begin
			packedWord.fields.exponent = '0;   // Underflow flushes, sign kept
			packedWord.fields.mantissa = '0;
		end else if (finalExp >= ExpMax) begin
			packedWord.fields.exponent = '1;   // Overflow to signed inf
			packedWord.fields.mantissa = '0;
		end
	end

	assign result = packedWord.raw;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the accumTree testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module accumTreeTb -o simAccumTree
./obj_dir/simAccumTree > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
	exit 0
else
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

// File: tb.f
hw/fp16Pkg.sv
hw/fpAlign.sv
hw/fpAddNorm.sv
hw/fpRound.sv
hw/fpAdder.sv
hw/accumTree.sv
verification/tbClock.sv
verification/accumTreeTb.sv

// File: verification/accumTreeTb.sv
`timescale 1ns/1ps

module accumTreeTb import fp16Pkg::*; ();
	localparam int ClockPeriod = 10;
	localparam int DirectedCount = 7;    // Directed sums plus specials
	localparam int RandomCount = 200;
	localparam int BurstCount = 12;
	localparam int MaxGap = 3;
	localparam int TotalStarts = DirectedCount + RandomCount + BurstCount;
	// Worst case per start is the longest gap plus a full wait and drain
	localparam int WatchdogCycles = TotalStarts * (MaxGap + TreeLatency + 12) + 50;

	logic ap_clk;
	logic ap_rst;
	logic start;
	logic [WordWidth-1:0] accumIn0;
	logic [WordWidth-1:0] accumIn1;
	logic [WordWidth-1:0] accumIn2;
	logic [WordWidth-1:0] accumIn3;
	logic done;
	logic [WordWidth-1:0] sum;
	logic idle;

	logic [WordWidth-1:0] expSumQ[$];   // Scoreboard, oldest first
	int expCycleQ[$];
	logic [WordWidth-1:0] expSum;
	int expCycle;
	logic expIdle;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors;
	logic [31:0] lcgState = 32'd11361;

	tbClock clkGen_i (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst)
	);

	accumTree dut_i (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.start(start),
		.accumIn0(accumIn0),
		.accumIn1(accumIn1),
		.accumIn2(accumIn2),
		.accumIn3(accumIn3),
		.done(done),
		.sum(sum),
		.idle(idle)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Any sign, exponent 1..30, any mantissa
	function automatic logic [WordWidth-1:0] randomNormal();
		logic [31:0] manBits;
		logic [31:0] expBits;
		int expo;
		manBits = nextRandom();
		expBits = nextRandom();
		expo = 1 + int'(expBits[27:16]) % 30;
		return {expBits[31], expo[4:0], manBits[31:22]};
	endfunction

	// Exact sum in units of 2^-24, then one rounding to nearest even
	function automatic logic [WordWidth-1:0] fp16Add(input logic [WordWidth-1:0] a,
		input logic [WordWidth-1:0] b);
		logic aNaN;
		logic bNaN;
		logic aInf;
		logic bInf;
		logic resSign;
		longint termA;
		longint termB;
		longint total;
		longint mag;
		longint quot;
		longint rem;
		longint half;
		int lead;
		int expo;
		aNaN = (a[14:10] == 5'h1F) && (a[9:0] != 10'h0);
		bNaN = (b[14:10] == 5'h1F) && (b[9:0] != 10'h0);
		aInf = (a[14:10] == 5'h1F) && (a[9:0] == 10'h0);
		bInf = (b[14:10] == 5'h1F) && (b[9:0] == 10'h0);
		if (aNaN || bNaN) return CanonNaN;
		if (aInf && bInf && (a[15] != b[15])) return CanonNaN;
		if (aInf) return a;
		if (bInf) return b;
		termA = 0;                       // Subnormals count as zero
		termB = 0;
		if (a[14:10] != 5'h0) termA = longint'(1024 + a[9:0]) << (a[14:10] - 1);
		if (b[14:10] != 5'h0) termB = longint'(1024 + b[9:0]) << (b[14:10] - 1);
		if (a[15]) termA = -termA;
		if (b[15]) termB = -termB;
		total = termA + termB;
		if (total == 0) return {a[15] & b[15], 15'h0};   // -0 only from two negatives
		resSign = (total < 0);
		mag = resSign ? -total : total;
		lead = 0;
		for (int i = 0; i < 48; i++) begin
			if (mag[i]) lead = i;
		end
		expo = lead - 9;                 // Biased exponent of the leading one
		if (lead >= 10) begin
			quot = mag >> (lead - 10);
			rem = mag - (quot << (lead - 10));
			if (lead >= 11) begin
				half = longint'(1) << (lead - 11);
				if (rem > half || (rem == half && quot[0])) quot = quot + 1;
			end
		end else begin
			quot = mag << (10 - lead);
		end
		if (quot == 2048) begin          // Round carried into a new binade
			quot = 1024;
			expo = expo + 1;
		end
		if (expo >= ExpMax) return {resSign, 5'h1F, 10'h0};
		if (expo <= 0) return {resSign, 15'h0};
		return {resSign, expo[4:0], quot[9:0]};
	endfunction

	// Same pairing as the hardware tree
	function automatic logic [WordWidth-1:0] fp16Tree(input logic [WordWidth-1:0] in0,
		input logic [WordWidth-1:0] in1, input logic [WordWidth-1:0] in2,
		input logic [WordWidth-1:0] in3);
		return fp16Add(fp16Add(in3, in2), fp16Add(in1, in0));
	endfunction

	always @(posedge ap_clk) cycleCount <= cycleCount + 1;

	// Scoreboard, runs mid-cycle where all DUT outputs have settled
	always @(negedge ap_clk) begin
		if (!ap_rst) begin
			expIdle = !(start || expSumQ.size() != 0);   // Before this cycle's pop
			checkCount++;
			if (idle !== expIdle) begin
				$display("[FAIL] t=%0t idle=%b expected=%b", $time, idle, expIdle);
				errorCount++;
			end
			if (done === 1'b1) begin
				if (expSumQ.size() == 0) begin
					$display("Error at t=%0t: done pulsed with no start pending", $time);
					errorCount++;
				end else begin
					expSum = expSumQ.pop_front();
					expCycle = expCycleQ.pop_front();
					checkCount += 2;
					if (sum !== expSum) begin
						$display("[FAIL] t=%0t sum=%h expected=%h", $time, sum, expSum);
						errorCount++;
					end
					if (cycleCount != expCycle) begin
						$display("[FAIL] t=%0t done cycle=%0d expected=%0d", $time,
							cycleCount, expCycle);
						errorCount++;
					end
				end
			end else if (expCycleQ.size() != 0 && cycleCount > expCycleQ[0]) begin
				$display("Error at t=%0t: done never came for the start due at cycle %0d",
					$time, expCycleQ[0]);
				errorCount++;
				void'(expSumQ.pop_front());
				void'(expCycleQ.pop_front());
			end
			if (start === 1'b1) begin
				expSumQ.push_back(fp16Tree(accumIn0, accumIn1, accumIn2, accumIn3));
				expCycleQ.push_back(cycleCount + TreeLatency);
			end
		end
	end

	// Leaves start high, the caller decides when it drops
	task automatic pulseStart(input logic [WordWidth-1:0] w0, input logic [WordWidth-1:0] w1,
		input logic [WordWidth-1:0] w2, input logic [WordWidth-1:0] w3);
		@(posedge ap_clk);
		start <= 1'b1;
		accumIn0 <= w0;
		accumIn1 <= w1;
		accumIn2 <= w2;
		accumIn3 <= w3;
	endtask

	task automatic gapCycles(input int count);
		if (count > 0) begin
			@(posedge ap_clk);
			start <= 1'b0;
			repeat (count - 1) @(posedge ap_clk);
		end
	endtask

	// One start, then its done checked against a known word
	task automatic runDirected(input logic [WordWidth-1:0] w0, input logic [WordWidth-1:0] w1,
		input logic [WordWidth-1:0] w2, input logic [WordWidth-1:0] w3,
		input logic [WordWidth-1:0] expected, input string label);
		int waited;
		waited = 0;
		pulseStart(w0, w1, w2, w3);
		gapCycles(1);
		@(negedge ap_clk);
		while (done !== 1'b1 && waited < TreeLatency + 4) begin
			@(negedge ap_clk);
			waited++;
		end
		checkCount++;
		if (done !== 1'b1) begin
			$display("Error at t=%0t: no done for the %s case", $time, label);
			errorCount++;
		end else if (sum !== expected) begin
			$display("[FAIL] t=%0t sum=%h expected=%h (%s)", $time, sum, expected, label);
			errorCount++;
		end
	endtask

	// Queue must empty, then idle must come back
	task automatic finishTest(input string name);
		int waited;
		waited = 0;
		while (expSumQ.size() != 0 && waited < TreeLatency + 10) begin
			@(negedge ap_clk);
			waited++;
		end
		checkCount++;
		if (expSumQ.size() != 0) begin
			$display("Error at t=%0t: %0d results still pending after %s", $time,
				expSumQ.size(), name);
			errorCount++;
		end else begin
			@(negedge ap_clk);
			if (idle !== 1'b1) begin
				$display("[FAIL] t=%0t idle=%b expected=1", $time, idle);
				errorCount++;
			end
		end
		$display("Test %s finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("Timeout: watchdog stopped the run at t=%0t", $time);
		$display("Checks failed");
		$finish;
	end

	initial begin
		start = 1'b0;
		accumIn0 = '0;
		accumIn1 = '0;
		accumIn2 = '0;
		accumIn3 = '0;
		testErrors = 0;
		@(negedge ap_clk);
		while (ap_rst) @(negedge ap_clk);

		checkCount++;
		if (done !== 1'b0 || idle !== 1'b1 || sum !== 16'h0000) begin
			$display("[FAIL] t=%0t done=%b idle=%b sum=%h expected 0 1 0000", $time,
				done, idle, sum);
			errorCount++;
		end
		$display("Test reset finished with %0d errors", errorCount - testErrors);
		testErrors = errorCount;

		runDirected(16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00, 16'h4400, "1+1+1+1");
		runDirected(16'h3C00, 16'hBC00, 16'h4000, 16'hC000, 16'h0000, "cancel to +0");
		// Odd tie goes up, even tie stays, the two then sum exactly
		runDirected(16'h3C00, 16'h6801, 16'h3C00, 16'h6800, 16'h6C01, "tie to even");
		finishTest("directed");

		for (int n = 0; n < RandomCount; n++) begin
			pulseStart(randomNormal(), randomNormal(), randomNormal(), randomNormal());
			gapCycles(int'(nextRandom() >> 16) % (MaxGap + 1));
		end
		gapCycles(1);
		finishTest("random");

		// Consecutive starts, done spacing comes from the scoreboard cycle check
		for (int n = 0; n < BurstCount; n++) begin
			pulseStart(randomNormal(), randomNormal(), randomNormal(), randomNormal());
		end
		gapCycles(1);
		finishTest("burst");

		runDirected(16'h7C01, 16'h3C00, 16'h3C00, 16'h3C00, CanonNaN, "NaN input");
		runDirected(16'h0000, 16'h0000, 16'hFC00, 16'h7C00, CanonNaN, "inf minus inf");
		runDirected(16'h7BFF, 16'h7BFF, 16'h7BFF, 16'h7BFF, 16'h7C00, "overflow");
		runDirected(16'h0000, 16'h0000, 16'h8400, 16'h0401, 16'h0000, "flush to zero");
		finishTest("specials");

		$display("Summary: %0d checks run, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic ap_clk,
	output logic ap_rst
);
	localparam int HalfPeriod = 5;    // 10 ns period
	localparam int ResetCycles = 3;

	initial begin
		ap_clk = 1'b0;
		forever #HalfPeriod ap_clk = ~ap_clk;
	end

	// Reset held over the first rising edges, released on an edge
	initial begin
		ap_rst = 1'b1;
		repeat (ResetCycles) @(posedge ap_clk);
		ap_rst <= 1'b0;
	end

endmodule
